// ==== build.f ====
cache_pkg.sv
cache_if.sv
cache_req_stage.sv
plru_tree.sv
cache_set_store.sv
cache_miss_ctrl.sv
cache_resp_stage.sv
data_cache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_data_cache.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_data_cache: build.f $(SRCS)
	verilator --binary --top-module tb_data_cache -f build.f -o Vtb_data_cache

run: obj_dir/Vtb_data_cache
	./obj_dir/Vtb_data_cache > sim.log 2>&1 || true
	cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_data_cache.sv ====
// testbench top with stimulus table, random response ready, memory monitor and checks
`timescale 1ns/1ps

module tb_data_cache import cache_pkg::*; ();

	typedef struct packed {
		logic rst;
		logic write;
		line_addr_t addr;
		line_data_t data;
		line_data_t exp_data;
		logic exp_hit;
		logic wb;
		line_addr_t wb_addr;
		line_data_t wb_data;
	} entry_t;

	localparam line_data_t d_021 = 64'h0021_1111_aaaa_0001;
	localparam line_data_t d_0a2 = 64'h00a2_2222_bbbb_0002;
	localparam line_data_t d_0b2 = 64'h00b2_3333_cccc_0003;
	localparam line_data_t d_0c2 = 64'h00c2_4444_dddd_0004;
	localparam line_data_t d_0d2 = 64'h00d2_5555_eeee_0005;
	localparam line_data_t d_0e2 = 64'h00e2_6666_ffff_0006;
	localparam line_data_t d_018 = 64'h0018_7777_1234_0007;
	localparam line_data_t d_020 = 64'h0020_8888_5678_0008;
	localparam line_data_t d_028 = 64'h0028_9999_9abc_0009;
	localparam line_data_t d_0a2_new = 64'h00a2_aaaa_def0_000a;

	logic clock;
	logic reset;
	logic reset_request;
	logic req_valid;
	logic req_ready;
	logic req_write;
	line_addr_t req_addr;
	line_data_t req_data;
	logic resp_valid;
	logic resp_ready = 1'b0;
	line_data_t resp_data;
	logic resp_hit;
	logic mem_req_valid;
	logic mem_req_ready;
	logic mem_req_write;
	line_addr_t mem_req_addr;
	line_data_t mem_req_data;
	logic mem_resp_valid;
	line_data_t mem_resp_data;

	logic [31:0] rand_q = 32'hc7cc;
	int wb_total = 0;
	int rd_total = 0;
	line_addr_t wb_last_addr = '0;
	line_data_t wb_last_data = '0;
	entry_t stim [$];

	tb_clock_gen i_clock_gen (.*);
	tb_mem_model i_mem_model (.*);
	data_cache_top i_data_cache_top (.*);

	function automatic line_data_t line_pattern(input line_addr_t a);
		return {16'hc0de, 4'h0, a, 4'h0, ~a, 16'h5a5a};
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic add_entry(input logic rst, input logic write, input line_addr_t addr,
			input line_data_t data, input line_data_t exp_data, input logic exp_hit,
			input logic wb, input line_addr_t wb_addr, input line_data_t wb_data);
		entry_t e;
		e = {rst, write, addr, data, exp_data, exp_hit, wb, wb_addr, wb_data};
		stim.push_back(e);
	endtask

	task automatic build_stimulus();
		// read miss after reset
		add_entry(1'b0, 1'b0, 12'h010, '0, line_pattern(12'h010), 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h021, d_021, d_021, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b0, 12'h021, '0, d_021, 1'b1, 1'b0, '0, '0);
		// set 2 fills ways 0 to 3, read of way 0, then tree picks way 2
		add_entry(1'b0, 1'b1, 12'h0a2, d_0a2, d_0a2, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h0b2, d_0b2, d_0b2, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h0c2, d_0c2, d_0c2, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h0d2, d_0d2, d_0d2, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b0, 12'h0a2, '0, d_0a2, 1'b1, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h0e2, d_0e2, d_0e2, 1'b0, 1'b1, 12'h0c2, d_0c2);
		// set 0 evicts the clean refilled line at way 0
		add_entry(1'b0, 1'b1, 12'h018, d_018, d_018, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h020, d_020, d_020, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h028, d_028, d_028, 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b0, 12'h030, '0, line_pattern(12'h030), 1'b0, 1'b0, '0, '0);
		// written-back line comes back from memory, evicting way 1
		add_entry(1'b0, 1'b0, 12'h0c2, '0, d_0c2, 1'b0, 1'b1, 12'h0b2, d_0b2);
		add_entry(1'b0, 1'b0, 12'h021, '0, d_021, 1'b1, 1'b0, '0, '0);
		add_entry(1'b0, 1'b1, 12'h0a2, d_0a2_new, d_0a2_new, 1'b1, 1'b0, '0, '0);
		add_entry(1'b0, 1'b0, 12'h0a2, '0, d_0a2_new, 1'b1, 1'b0, '0, '0);
		// dirty data lost on reset, written-back data kept
		add_entry(1'b1, 1'b0, 12'h021, '0, line_pattern(12'h021), 1'b0, 1'b0, '0, '0);
		add_entry(1'b0, 1'b0, 12'h0b2, '0, d_0b2, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (reset && cycles < 20);
		if (reset)
			stop_run("reset was never released");
	endtask

	task automatic send_request(input int idx);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		req_valid <= 1'b1;
		req_write <= stim[idx].write;
		req_addr <= stim[idx].addr;
		req_data <= stim[idx].data;
		while (!done && cycles < 100) begin
			@(posedge clock);
			cycles++;
			done = req_ready;
		end
		req_valid <= 1'b0;
		if (!done)
			stop_run($sformatf("timeout at %0t, request %0d never accepted", $time, idx));
	endtask

	task automatic wait_response(input int idx, output line_data_t data, output logic hit);
		int cycles;
		logic done;
		logic held;
		line_data_t held_data;
		logic held_hit;
		cycles = 0;
		done = 1'b0;
		held = 1'b0;
		held_data = '0;
		held_hit = 1'b0;
		data = '0;
		hit = 1'b0;
		while (!done && cycles < 300) begin
			@(posedge clock);
			cycles++;
			// stalled response must not move
			if (held) begin
				assert (resp_valid && resp_data == held_data && resp_hit == held_hit)
				else stop_run($sformatf("[ERROR] %0t: response %0d changed while stalled",
					$time, idx));
			end
			if (resp_valid && resp_ready) begin
				data = resp_data;
				hit = resp_hit;
				done = 1'b1;
			end else if (resp_valid) begin
				held = 1'b1;
				held_data = resp_data;
				held_hit = resp_hit;
			end
		end
		if (!done)
			stop_run($sformatf("timeout at %0t waiting for response %0d", $time, idx));
	endtask

	// client stalls about half the cycles
	always @(posedge clock) begin
		rand_q <= next_random(rand_q);
		resp_ready <= rand_q[22];
	end

	// memory traffic monitor
	always @(posedge clock) begin
		if (mem_req_valid && mem_req_ready) begin
			if (mem_req_write) begin
				wb_total <= wb_total + 1;
				wb_last_addr <= mem_req_addr;
				wb_last_data <= mem_req_data;
			end else begin
				rd_total <= rd_total + 1;
			end
		end
	end

	initial begin
		line_data_t got_data;
		logic got_hit;
		int wb_base;
		int rd_base;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		reset_request = 1'b0;
		build_stimulus();
		wait_reset_release();
		for (int i = 0; i < stim.size(); i++) begin
			if (stim[i].rst) begin
				reset_request <= 1'b1;
				@(posedge clock);
				reset_request <= 1'b0;
				wait_reset_release();
			end
			wb_base = wb_total;
			rd_base = rd_total;
			send_request(i);
			wait_response(i, got_data, got_hit);
			assert (got_data == stim[i].exp_data && got_hit == stim[i].exp_hit)
			else stop_run($sformatf("[ERROR] %0t: entry %0d gave %h hit %b, expected %h hit %b",
				$time, i, got_data, got_hit, stim[i].exp_data, stim[i].exp_hit));
			assert (wb_total - wb_base == (stim[i].wb ? 1 : 0))
			else stop_run($sformatf("[ERROR] %0t: entry %0d made %0d write-backs",
				$time, i, wb_total - wb_base));
			if (stim[i].wb) begin
				assert (wb_last_addr == stim[i].wb_addr && wb_last_data == stim[i].wb_data)
				else stop_run($sformatf("[ERROR] %0t: entry %0d wrote back %h data %h",
					$time, i, wb_last_addr, wb_last_data));
			end
			// only a read miss goes to memory for a refill
			assert (rd_total - rd_base == ((!stim[i].write && !stim[i].exp_hit) ? 1 : 0))
			else stop_run($sformatf("[ERROR] %0t: entry %0d made %0d memory reads",
				$time, i, rd_total - rd_base));
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== tb_mem_model.sv ====
// backing memory model with address pattern contents and random request ready
`timescale 1ns/1ps

module tb_mem_model import cache_pkg::*; #(
	parameter logic [31:0] seed = 32'hc7cc
) (
	input logic clock,
	input logic reset,
	input logic mem_req_valid,
	output logic mem_req_ready,
	input logic mem_req_write,
	input line_addr_t mem_req_addr,
	input line_data_t mem_req_data,
	output logic mem_resp_valid,
	output line_data_t mem_resp_data
);

	line_data_t mem [1 << addr_bits];
	logic [31:0] rand_q;
	logic pending;
	line_addr_t rd_addr;

	function automatic line_data_t line_pattern(input line_addr_t a);
		return {16'hc0de, 4'h0, a, 4'h0, ~a, 16'h5a5a};
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		for (int a = 0; a < (1 << addr_bits); a++)
			mem[a] = line_pattern(line_addr_t'(a));
		rand_q = seed;
		pending = 1'b0;
		rd_addr = '0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
	end

	// ready about three cycles in four
	always @(posedge clock) begin
		rand_q <= next_random(rand_q);
		mem_req_ready <= (rand_q[27:26] != 2'b00);
		mem_resp_valid <= 1'b0;
		if (reset) begin
			pending <= 1'b0;
		end else if (pending) begin
			// read data is seen two edges after acceptance
			mem_resp_valid <= 1'b1;
			mem_resp_data <= mem[rd_addr];
			pending <= 1'b0;
		end else if (mem_req_valid && mem_req_ready) begin
			if (mem_req_write) begin
				mem[mem_req_addr] <= mem_req_data;
			end else begin
				pending <= 1'b1;
				rd_addr <= mem_req_addr;
			end
		end
	end

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source
`timescale 1ns/1ps

module tb_clock_gen (
	input logic reset_request,
	output logic clock,
	output logic reset
);

	int hold;

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		hold = 3;
	end

	// reset stays high for three rising edges
	always @(posedge clock) begin
		if (reset_request) begin
			reset <= 1'b1;
			hold <= 3;
		end else if (hold > 0) begin
			reset <= (hold > 1);
			hold <= hold - 1;
		end
	end

endmodule

// ==== data_cache_top.sv ====
// data cache top with client and memory ports
`timescale 1ns/1ps

module data_cache_top import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input line_addr_t req_addr,
	input line_data_t req_data,
	output logic resp_valid,
	input logic resp_ready,
	output line_data_t resp_data,
	output logic resp_hit,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output logic mem_req_write,
	output line_addr_t mem_req_addr,
	output line_data_t mem_req_data,
	input logic mem_resp_valid,
	input line_data_t mem_resp_data
);

	cache_req_if req_if ();
	cache_array_if arr_if ();
	cache_resp_if resp_if ();

	cache_req_stage i_req_stage (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_data(req_data),
		.out(req_if.src)
	);

	cache_miss_ctrl i_miss_ctrl (
		.clock(clock),
		.reset(reset),
		.req(req_if.dst),
		.arr(arr_if.ctrl),
		.resp(resp_if.src),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_write(mem_req_write),
		.mem_req_addr(mem_req_addr),
		.mem_req_data(mem_req_data),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

	cache_set_store i_set_store (
		.clock(clock),
		.reset(reset),
		.arr(arr_if.store)
	);

	cache_resp_stage i_resp_stage (
		.clock(clock),
		.reset(reset),
		.in(resp_if.dst),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp_data(resp_data),
		.resp_hit(resp_hit)
	);

endmodule

// ==== cache_resp_stage.sv ====
// one-entry response buffer toward the client
`timescale 1ns/1ps

module cache_resp_stage import cache_pkg::*; (
	input logic clock,
	input logic reset,
	cache_resp_if.dst in,
	output logic resp_valid,
	input logic resp_ready,
	output line_data_t resp_data,
	output logic resp_hit
);

	logic full;
	line_data_t data_q;
	logic hit_q;
	logic load;

	assign in.ready = !full || resp_ready;
	assign load = in.valid && in.ready;

	always_ff @(posedge clock) begin
		if (reset)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;
		else if (resp_ready)
			full <= 1'b0;
	end

	// entry stays put while the client stalls
	always_ff @(posedge clock) begin
		if (load) begin
			data_q <= in.data;
			hit_q <= in.hit;
		end
	end

	assign resp_valid = full;
	assign resp_data = data_q;
	assign resp_hit = hit_q;

endmodule

// ==== cache_miss_ctrl.sv ====
// controller FSM for hits, dirty write-back, refill and response issue
`timescale 1ns/1ps

module cache_miss_ctrl import cache_pkg::*; (
	input logic clock,
	input logic reset,
	cache_req_if.dst req,
	cache_array_if.ctrl arr,
	cache_resp_if.src resp,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output logic mem_req_write,
	output line_addr_t mem_req_addr,
	output line_data_t mem_req_data,
	input logic mem_resp_valid,
	input line_data_t mem_resp_data
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic write_q;
	set_idx_t idx_q;
	tag_t tag_q;
	line_data_t line_q;
	way_t victim_way_q;
	tag_t victim_tag_q;
	line_data_t victim_data_q;
	logic miss;

	assign miss = (state == idle) && req.valid && !arr.hit;

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	// line_q holds write data, or the refill data on a read miss
	always_ff @(posedge clock) begin
		if (miss) begin
			write_q <= req.write;
			idx_q <= req.idx;
			tag_q <= req.tag;
			line_q <= req.data;
			victim_way_q <= arr.victim_way;
			victim_tag_q <= arr.victim_tag;
			victim_data_q <= arr.victim_data;
		end else if (state == refill_wait && mem_resp_valid) begin
			line_q <= mem_resp_data;
		end
	end

	assign mem_req_valid = (state == write_back) || (state == refill_req);
	assign mem_req_write = (state == write_back);
	assign mem_req_addr = (state == write_back) ? {victim_tag_q, idx_q} : {tag_q, idx_q};
	assign mem_req_data = victim_data_q;

	always_comb begin
		state_next = state;
		req.ready = 1'b0;
		resp.valid = 1'b0;
		resp.data = line_q;
		resp.hit = 1'b0;
		arr.idx = idx_q;
		arr.tag = tag_q;
		arr.wr_en = 1'b0;
		arr.wr_data = line_q;
		arr.wr_dirty = write_q;
		arr.fill_en = 1'b0;
		arr.touch_en = 1'b0;
		arr.lookup_way = victim_way_q;
		case (state)
			idle: begin
				arr.idx = req.idx;
				arr.tag = req.tag;
				arr.wr_data = req.data;
				arr.wr_dirty = 1'b1;
				arr.lookup_way = arr.hit_way;
				if (req.valid && arr.hit) begin
					resp.valid = 1'b1;
					resp.hit = 1'b1;
					resp.data = req.write ? req.data : arr.rd_data;
					if (resp.ready) begin
						req.ready = 1'b1;
						arr.wr_en = req.write;
						arr.touch_en = 1'b1;
					end
				end else if (miss) begin
					// only a valid dirty victim goes back to memory
					if (arr.victim_valid && arr.victim_dirty)
						state_next = write_back;
					else if (req.write)
						state_next = respond;
					else
						state_next = refill_req;
				end
			end
			write_back: begin
				if (mem_req_ready)
					state_next = write_q ? respond : refill_req;
			end
			refill_req: begin
				if (mem_req_ready)
					state_next = refill_wait;
			end
			refill_wait: begin
				if (mem_resp_valid)
					state_next = respond;
			end
			respond: begin
				resp.valid = 1'b1;
				// install only once the response is passed on
				if (resp.ready) begin
					req.ready = 1'b1;
					arr.fill_en = 1'b1;
					arr.touch_en = 1'b1;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

endmodule

// ==== cache_set_store.sv ====
// 4-way line store with tag compare, valid/dirty flags, victim choice and writes
`timescale 1ns/1ps

module cache_set_store import cache_pkg::*; (
	input logic clock,
	input logic reset,
	cache_array_if.store arr
);

	logic [num_ways-1:0] valid_q [num_sets];
	logic [num_ways-1:0] dirty_q [num_sets];
	tag_t tag_q [num_sets][num_ways];
	line_data_t data_q [num_sets][num_ways];

	logic [num_ways-1:0] set_valid;
	logic [num_ways-1:0] set_dirty;
	logic [num_ways-1:0] hit_vec;
	way_t hit_way;
	logic inv_found;
	way_t inv_way;
	way_t plru_victim;
	way_t victim_way;
	logic line_wr;

	plru_tree i_plru_tree (
		.clock(clock),
		.reset(reset),
		.idx(arr.idx),
		.touch_en(arr.touch_en),
		.touch_way(arr.lookup_way),
		.victim_way(plru_victim)
	);

	assign set_valid = valid_q[arr.idx];
	assign set_dirty = dirty_q[arr.idx];

	// tag compare across the indexed set
	always_comb begin
		for (int w = 0; w < num_ways; w++)
			hit_vec[w] = set_valid[w] && (tag_q[arr.idx][w] == arr.tag);
	end

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	// lowest free way wins over the tree choice
	always_comb begin
		inv_found = 1'b0;
		inv_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!set_valid[w]) begin
				inv_found = 1'b1;
				inv_way = way_t'(w);
			end
		end
	end

	assign victim_way = inv_found ? inv_way : plru_victim;

	assign arr.hit = |hit_vec;
	assign arr.hit_way = hit_way;
	assign arr.rd_data = data_q[arr.idx][hit_way];
	assign arr.victim_way = victim_way;
	assign arr.victim_valid = set_valid[victim_way];
	assign arr.victim_dirty = set_dirty[victim_way];
	assign arr.victim_tag = tag_q[arr.idx][victim_way];
	assign arr.victim_data = data_q[arr.idx][victim_way];

	assign line_wr = arr.wr_en || arr.fill_en;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (line_wr) begin
			dirty_q[arr.idx][arr.lookup_way] <= arr.wr_dirty;
			if (arr.fill_en)
				valid_q[arr.idx][arr.lookup_way] <= 1'b1;
		end
	end

	// fill installs a new tag, a plain write keeps it
	always_ff @(posedge clock) begin
		if (line_wr)
			data_q[arr.idx][arr.lookup_way] <= arr.wr_data;
		if (arr.fill_en)
			tag_q[arr.idx][arr.lookup_way] <= arr.tag;
	end

endmodule

// ==== plru_tree.sv ====
// per-set tree pseudo-LRU state with touch update and victim way
`timescale 1ns/1ps

module plru_tree import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input set_idx_t idx,
	input logic touch_en,
	input way_t touch_way,
	output way_t victim_way
);

	plru_bits_t tree_q [num_sets];
	plru_bits_t cur;

	assign cur = tree_q[idx];

	// root picks the pair, pair bit picks the way inside it
	assign victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++)
				tree_q[s] <= '0;
		end else if (touch_en) begin
			// point away from the touched way
			tree_q[idx][0] <= ~touch_way[1];
			if (touch_way[1])
				tree_q[idx][2] <= ~touch_way[0];
			else
				tree_q[idx][1] <= ~touch_way[0];
		end
	end

endmodule

// ==== cache_req_stage.sv ====
// client request register with index/tag split
`timescale 1ns/1ps

module cache_req_stage import cache_pkg::*; (
	input logic clock,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input line_addr_t req_addr,
	input line_data_t req_data,
	cache_req_if.src out
);

	logic full;
	logic rdy_en;
	logic write_q;
	line_addr_t addr_q;
	line_data_t data_q;
	logic take;

	// rdy_en keeps ready low for the first cycle out of reset
	assign req_ready = rdy_en && (!full || out.ready);
	assign take = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			full <= 1'b0;
			rdy_en <= 1'b0;
		end else begin
			rdy_en <= 1'b1;
			if (take)
				full <= 1'b1;
			else if (out.ready)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			write_q <= req_write;
			addr_q <= req_addr;
			data_q <= req_data;
		end
	end

	assign out.valid = full;
	assign out.write = write_q;
	assign out.idx = addr_q[idx_bits-1:0];
	assign out.tag = addr_q[addr_bits-1:idx_bits];
	assign out.data = data_q;

endmodule

// ==== cache_if.sv ====
// request, line store access and response interfaces with their modports
`timescale 1ns/1ps

interface cache_req_if import cache_pkg::*; ();
	logic valid;
	logic ready;
	logic write;
	set_idx_t idx;
	tag_t tag;
	line_data_t data;

	modport src (output valid, write, idx, tag, data, input ready);
	modport dst (input valid, write, idx, tag, data, output ready);
endinterface

interface cache_array_if import cache_pkg::*; ();
	// controller side
	set_idx_t idx;
	tag_t tag;
	logic wr_en;
	line_data_t wr_data;
	logic wr_dirty;
	logic fill_en;
	logic touch_en;
	way_t lookup_way;
	// store side
	logic hit;
	way_t hit_way;
	line_data_t rd_data;
	way_t victim_way;
	logic victim_valid;
	logic victim_dirty;
	tag_t victim_tag;
	line_data_t victim_data;

	modport ctrl (
		output idx, tag, wr_en, wr_data, wr_dirty, fill_en, touch_en, lookup_way,
		input hit, hit_way, rd_data, victim_way, victim_valid, victim_dirty,
		input victim_tag, victim_data
	);
	modport store (
		input idx, tag, wr_en, wr_data, wr_dirty, fill_en, touch_en, lookup_way,
		output hit, hit_way, rd_data, victim_way, victim_valid, victim_dirty,
		output victim_tag, victim_data
	);
endinterface

interface cache_resp_if import cache_pkg::*; ();
	logic valid;
	logic ready;
	line_data_t data;
	logic hit;

	modport src (output valid, data, hit, input ready);
	modport dst (input valid, data, hit, output ready);
endinterface

// ==== cache_pkg.sv ====
// cache geometry constants, width typedefs and controller state encoding

package cache_pkg;

	localparam int num_sets = 8;
	localparam int num_ways = 4;
	localparam int line_bits = 64;
	localparam int addr_bits = 12;

	// derived field widths
	localparam int idx_bits = $clog2(num_sets);
	localparam int tag_bits = addr_bits - idx_bits;
	localparam int way_bits = $clog2(num_ways);

	// index is the low part of the line address, tag the high part
	typedef logic [idx_bits-1:0] set_idx_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [way_bits-1:0] way_t;
	typedef logic [addr_bits-1:0] line_addr_t;
	typedef logic [line_bits-1:0] line_data_t;

	// bit 0 root, bit 1 pair of ways 0-1, bit 2 pair of ways 2-3
	typedef logic [num_ways-2:0] plru_bits_t;

	typedef enum logic [2:0] {
		idle,
		write_back,
		refill_req,
		refill_wait,
		respond
	} ctrl_state_t;

endpackage
